// File: verilog/pipe_pkg.sv
package pipe_pkg;

	localparam int reg_bits = 5;	// register number width
	localparam int tag_bits = 8;	// token tag width

	// one instruction token, no opcode or operand values, only what the hazards need
	typedef struct packed {
		logic                valid;
		logic [tag_bits-1:0] tag;
		logic [reg_bits-1:0] rs;
		logic [reg_bits-1:0] rt;
		logic [reg_bits-1:0] rd;	// destination, zero means no write
		logic                is_load;
		logic                is_store;
		logic                is_branch;
		logic                br_taken;	// outcome is known once the branch reaches MEM
		logic                is_jump;
		logic                is_syscall;
	} instr_t;

	// write and bubble enables for the PC and the four stage registers
	typedef struct packed {
		logic write_pc;
		logic write_ifid;
		logic write_idex;
		logic write_exmem;
		logic write_memwb;
		logic bubble_ifid;
		logic bubble_idex;
		logic bubble_exmem;
		logic bubble_memwb;
	} stage_ctrl_t;

	// winning cause of the current cycle, for observation only
	typedef enum logic [2:0] {
		HZ_NONE      = 3'd0,
		HZ_MEM_WAIT  = 3'd1,
		HZ_TRAP_HOLD = 3'd2,
		HZ_LOAD_USE  = 3'd3,
		HZ_JUMP      = 3'd4,
		HZ_BRANCH    = 3'd5,
		HZ_TRAP      = 3'd6
	} hazard_e;

	typedef enum logic [1:0] {
		TRAP_IDLE  = 2'd0,
		TRAP_HOLD  = 2'd1,	// syscall waits in ID behind a branch
		TRAP_ISSUE = 2'd2	// trap goes out this cycle
	} trap_state_e;

endpackage

// File: verilog/hazard_detect.sv
`timescale 1ns/100ps

module hazard_detect (
	input  pipe_pkg::instr_t      ifid,
	input  pipe_pkg::instr_t      idex,
	input  pipe_pkg::instr_t      exmem,
	input  logic                  mem_ready,
	input  logic                  trap_hold,
	input  logic                  trap_fire,
	output pipe_pkg::stage_ctrl_t ctrl,
	output logic                  redirect,
	output pipe_pkg::hazard_e     hazard
);

	logic load_use;
	logic branch_next;
	logic jump_id;
	logic branch_flush;

	// r0 is hardwired to zero, so a load into it feeds nobody
	assign load_use = idex.valid && idex.is_load && (idex.rd != '0) && ifid.valid &&
		((idex.rd == ifid.rs) || (idex.rd == ifid.rt));

	// a taken branch one stage ahead flushes the jump next cycle anyway
	assign branch_next = idex.valid && idex.is_branch && idex.br_taken;
	assign jump_id = ifid.valid && ifid.is_jump && !branch_next;

	assign branch_flush = exmem.valid && exmem.is_branch && exmem.br_taken;	// resolved in MEM

	always_comb begin
		ctrl.write_pc     = 1'b1;
		ctrl.write_ifid   = 1'b1;
		ctrl.write_idex   = 1'b1;
		ctrl.write_exmem  = 1'b1;
		ctrl.write_memwb  = 1'b1;
		ctrl.bubble_ifid  = 1'b0;
		ctrl.bubble_idex  = 1'b0;
		ctrl.bubble_exmem = 1'b0;
		ctrl.bubble_memwb = 1'b0;
		redirect          = 1'b0;
		hazard            = pipe_pkg::HZ_NONE;

		if (!mem_ready) begin
			// data memory busy, whole pipe stands still
			ctrl.write_pc    = 1'b0;
			ctrl.write_ifid  = 1'b0;
			ctrl.write_idex  = 1'b0;
			ctrl.write_exmem = 1'b0;
			ctrl.write_memwb = 1'b0;
			hazard           = pipe_pkg::HZ_MEM_WAIT;
		end else begin
			if (trap_fire) begin
				// syscall moves on, fetch restarts at the handler
				ctrl.bubble_ifid = 1'b1;
				redirect         = 1'b1;
				hazard           = pipe_pkg::HZ_TRAP;
			end else if (trap_hold) begin
				ctrl.write_pc    = 1'b0;	// keep the syscall in ID
				ctrl.write_ifid  = 1'b0;
				ctrl.bubble_idex = 1'b1;
				hazard           = pipe_pkg::HZ_TRAP_HOLD;
			end else if (load_use) begin
				ctrl.write_pc    = 1'b0;
				ctrl.write_ifid  = 1'b0;
				ctrl.bubble_idex = 1'b1;	// one slot for the load data
				hazard           = pipe_pkg::HZ_LOAD_USE;
			end else if (jump_id) begin
				ctrl.bubble_ifid = 1'b1;	// drop the token fetched behind the jump
				redirect         = 1'b1;
				hazard           = pipe_pkg::HZ_JUMP;
			end

			// taken branch overrides the ID stage decisions
			if (branch_flush) begin
				ctrl.write_pc     = 1'b1;
				ctrl.write_ifid   = 1'b1;	// held registers must take the bubble too
				ctrl.write_idex   = 1'b1;
				ctrl.write_exmem  = 1'b1;
				ctrl.bubble_ifid  = 1'b1;
				ctrl.bubble_idex  = 1'b1;
				ctrl.bubble_exmem = 1'b1;
				redirect          = 1'b1;
				hazard            = pipe_pkg::HZ_BRANCH;
			end
		end
	end

endmodule

// File: verilog/trap_seq.sv
`timescale 1ns/100ps

module trap_seq (
	input  logic                          clk,
	input  logic                          arst_n,
	input  pipe_pkg::instr_t              ifid,
	input  pipe_pkg::instr_t              idex,
	input  pipe_pkg::instr_t              exmem,
	input  logic                          mem_ready,
	output logic                          trap_hold,
	output logic                          trap_fire,
	output logic                          trap_taken,
	output logic [pipe_pkg::tag_bits-1:0] trap_tag
);

	pipe_pkg::trap_state_e state;
	pipe_pkg::trap_state_e state_nxt;
	logic sys_id;
	logic branch_ahead;

	assign sys_id = ifid.valid && ifid.is_syscall;

	// any older branch, taken or not, has to resolve before the trap
	assign branch_ahead = (idex.valid && idex.is_branch) || (exmem.valid && exmem.is_branch);

	assign trap_hold = sys_id && branch_ahead && (state != pipe_pkg::TRAP_ISSUE);
	assign trap_fire = sys_id && !branch_ahead && mem_ready &&
		(state != pipe_pkg::TRAP_ISSUE);

	assign trap_taken = (state == pipe_pkg::TRAP_ISSUE);	// one cycle after fire

	always_comb begin
		state_nxt = state;
		case (state)
			pipe_pkg::TRAP_IDLE: begin
				if (mem_ready && sys_id) begin
					state_nxt = branch_ahead ? pipe_pkg::TRAP_HOLD : pipe_pkg::TRAP_ISSUE;
				end
			end
			pipe_pkg::TRAP_HOLD: begin
				if (!sys_id) begin
					// flushed by an older taken branch
					state_nxt = pipe_pkg::TRAP_IDLE;
				end else if (trap_fire) begin
					state_nxt = pipe_pkg::TRAP_ISSUE;
				end
			end
			pipe_pkg::TRAP_ISSUE: begin
				state_nxt = pipe_pkg::TRAP_IDLE;
			end
			default: begin
				state_nxt = pipe_pkg::TRAP_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= pipe_pkg::TRAP_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// tag of the syscall that fired, valid while trap_taken is high
	always_ff @(posedge clk) begin
		if (trap_fire) begin
			trap_tag <= ifid.tag;
		end
	end

endmodule

// File: verilog/mem_wait_timer.sv
`timescale 1ns/100ps

module mem_wait_timer #(
	parameter int mem_latency = 3
) (
	input  logic             clk,
	input  logic             arst_n,
	input  pipe_pkg::instr_t exmem,
	input  logic             write_exmem,
	output logic             mem_ready
);

	localparam int cnt_bits = 3;	// enough for a latency of 1 to 7

	logic [cnt_bits-1:0] count;
	logic [cnt_bits-1:0] remaining;
	logic mem_op;
	logic served;
	logic pending;

	assign mem_op = exmem.valid && (exmem.is_load || exmem.is_store);
	assign pending = mem_op && !served;	// access in MEM not yet finished
	assign mem_ready = !pending;

	// first wait cycle starts from the full latency
	assign remaining = (count == '0) ? cnt_bits'(mem_latency) : count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count  <= '0;
			served <= 1'b0;
		end else if (write_exmem) begin
			// token leaves MEM, whatever lands next gets its own wait
			count  <= '0;
			served <= 1'b0;
		end else if (pending) begin
			count  <= remaining - 1'b1;
			served <= (remaining == cnt_bits'(1));	// last wait cycle
		end
	end

endmodule

// File: verilog/stage_regs.sv
`timescale 1ns/100ps

module stage_regs (
	input  logic                  clk,
	input  logic                  arst_n,
	input  pipe_pkg::instr_t      fetch_instr,
	input  pipe_pkg::stage_ctrl_t ctrl,
	output pipe_pkg::instr_t      ifid,
	output pipe_pkg::instr_t      idex,
	output pipe_pkg::instr_t      exmem,
	output pipe_pkg::instr_t      memwb
);

	localparam int n_stages = 4;

	pipe_pkg::instr_t stage_d [n_stages];	// what each register would load
	pipe_pkg::instr_t payload_q [n_stages];
	pipe_pkg::instr_t stage_q [n_stages];
	logic [n_stages-1:0] valid_q;
	logic [n_stages-1:0] wr;
	logic [n_stages-1:0] bub;

	// index 0 is IF/ID, 3 is MEM/WB
	assign wr = {ctrl.write_memwb, ctrl.write_exmem, ctrl.write_idex, ctrl.write_ifid};
	assign bub = {ctrl.bubble_memwb, ctrl.bubble_exmem, ctrl.bubble_idex, ctrl.bubble_ifid};

	assign stage_d[0] = fetch_instr;
	assign stage_d[1] = stage_q[0];
	assign stage_d[2] = stage_q[1];
	assign stage_d[3] = stage_q[2];

	for (genvar i = 0; i < n_stages; i++) begin : g_stage
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				valid_q[i] <= 1'b0;
			end else if (wr[i]) begin
				valid_q[i] <= stage_d[i].valid && !bub[i];	// a bubble is just an invalid token
			end
		end

		// tag, registers and flags are don't care while the valid bit is low
		always_ff @(posedge clk) begin
			if (wr[i]) begin
				payload_q[i] <= stage_d[i];
			end
		end

		always_comb begin
			stage_q[i]       = payload_q[i];
			stage_q[i].valid = valid_q[i];
		end
	end

	assign ifid  = stage_q[0];
	assign idex  = stage_q[1];
	assign exmem = stage_q[2];
	assign memwb = stage_q[3];

endmodule

// File: verilog/pipe_ctrl_top.sv
`timescale 1ns/100ps

module pipe_ctrl_top #(
	parameter int mem_latency = 3	// wait cycles per load or store
) (
	input  logic                          clk,
	input  logic                          arst_n,
	input  pipe_pkg::instr_t              fetch_instr,
	output logic                          fetch_take,
	output logic                          redirect,
	output pipe_pkg::instr_t              retire,
	output logic                          trap_taken,
	output logic [pipe_pkg::tag_bits-1:0] trap_tag,
	output pipe_pkg::hazard_e             hazard
);

	pipe_pkg::instr_t ifid;
	pipe_pkg::instr_t idex;
	pipe_pkg::instr_t exmem;
	pipe_pkg::instr_t memwb;
	pipe_pkg::stage_ctrl_t ctrl;
	logic mem_ready;
	logic trap_hold;
	logic trap_fire;

	assign fetch_take = ctrl.write_pc;	// source advances whenever PC is written
	assign retire = memwb;

	hazard_detect u_hazard (
		.ifid      (ifid),
		.idex      (idex),
		.exmem     (exmem),
		.mem_ready (mem_ready),
		.trap_hold (trap_hold),
		.trap_fire (trap_fire),
		.ctrl      (ctrl),
		.redirect  (redirect),
		.hazard    (hazard)
	);

	trap_seq u_trap (
		.clk        (clk),
		.arst_n     (arst_n),
		.ifid       (ifid),
		.idex       (idex),
		.exmem      (exmem),
		.mem_ready  (mem_ready),
		.trap_hold  (trap_hold),
		.trap_fire  (trap_fire),
		.trap_taken (trap_taken),
		.trap_tag   (trap_tag)
	);

	mem_wait_timer #(
		.mem_latency (mem_latency)
	) u_mem_timer (
		.clk         (clk),
		.arst_n      (arst_n),
		.exmem       (exmem),
		.write_exmem (ctrl.write_exmem),
		.mem_ready   (mem_ready)
	);

	stage_regs u_stages (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_instr (fetch_instr),
		.ctrl        (ctrl),
		.ifid        (ifid),
		.idex        (idex),
		.exmem       (exmem),
		.memwb       (memwb)
	);

endmodule

// File: sim/pipe_ctrl_properties.sv
`timescale 1ns/100ps

module pipe_ctrl_properties (
	input logic              clk,
	input logic              arst_n,
	input logic              mem_ready,
	input pipe_pkg::instr_t  ifid,
	input pipe_pkg::instr_t  idex,
	input pipe_pkg::instr_t  exmem,
	input pipe_pkg::instr_t  memwb,
	input logic              redirect,
	input pipe_pkg::hazard_e hazard
);

	int fail_count = 0;

	// busy data memory freezes the PC and every stage register
	mem_wait_freeze: assert property (@(posedge clk) disable iff (!arst_n)
		!mem_ready |=> $stable(ifid) && $stable(idex) && $stable(exmem) && $stable(memwb))
		else begin
			$error("stage register changed while the data memory is busy");
			fail_count++;
		end

	redirect_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		redirect |=> !redirect)
		else begin
			$error("redirect high for more than one cycle");
			fail_count++;
		end

	// consumer waits in ID while a bubble goes on to EX
	load_use_hold: assert property (@(posedge clk) disable iff (!arst_n)
		hazard == pipe_pkg::HZ_LOAD_USE |=> $stable(ifid) && !idex.valid)
		else begin
			$error("load-use stall did not hold IF/ID");	// fetch must wait for load data
			fail_count++;
		end

endmodule

bind pipe_ctrl_top pipe_ctrl_properties u_props (
	.clk       (clk),
	.arst_n    (arst_n),
	.mem_ready (mem_ready),
	.ifid      (ifid),
	.idex      (idex),
	.exmem     (exmem),
	.memwb     (memwb),
	.redirect  (redirect),
	.hazard    (hazard)
);

// File: sim/pipe_ctrl_tb.sv
`timescale 1ns/100ps

module pipe_ctrl_tb;

	localparam int mem_latency = 3;
	localparam int run_cycles = 2000;
	localparam int drain_limit = 300;
	localparam int n_tests = 5;
	localparam int t_reset = 0;
	localparam int t_retire = 1;
	localparam int t_mem = 2;
	localparam int t_load_use = 3;
	localparam int t_redirect = 4;

	logic                          clk;
	logic                          arst_n;
	pipe_pkg::instr_t              fetch_instr;
	logic                          fetch_take;
	logic                          redirect;
	pipe_pkg::instr_t              retire;
	logic                          trap_taken;
	logic [pipe_pkg::tag_bits-1:0] trap_tag;
	pipe_pkg::hazard_e             hazard;

	pipe_pkg::instr_t              expect_q [$];	// live tokens in consume order
	logic [pipe_pkg::tag_bits-1:0] trap_q [$];	// tags of live syscalls
	pipe_pkg::instr_t              prev_tok;
	pipe_pkg::instr_t              wait_retire;
	logic                          prev_live;	// last consumed token was live
	logic                          in_shadow;
	logic                          took;
	logic                          feeding;
	logic                          prev_wait;
	logic [pipe_pkg::tag_bits-1:0] next_tag;
	int wait_len;
	int wait_runs;
	int mem_retired;
	int load_use_exp;
	int load_use_seen;
	int checks [n_tests];
	int errs [n_tests];

	pipe_ctrl_top #(
		.mem_latency (mem_latency)
	) u_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_instr (fetch_instr),
		.fetch_take  (fetch_take),
		.redirect    (redirect),
		.retire      (retire),
		.trap_taken  (trap_taken),
		.trap_tag    (trap_tag),
		.hazard      (hazard)
	);

	always #10 clk = ~clk;

	task automatic compare_value(input int test, input logic [31:0] got,
		input logic [31:0] exp, input string what);
		checks[test]++;
		if (got !== exp) begin
			errs[test]++;
			$display("ERROR t=%0t: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic pipe_pkg::instr_t random_token(input logic [pipe_pkg::tag_bits-1:0] tag);
		pipe_pkg::instr_t tok;
		logic [31:0] r;
		int kind;
		r         = $urandom;
		kind      = $urandom % 100;
		tok       = '0;
		tok.valid = 1'b1;
		tok.tag   = tag;
		tok.rs    = {2'b00, r[2:0]};	// eight registers keep dependencies frequent
		tok.rt    = {2'b00, r[5:3]};
		tok.rd    = {2'b00, r[8:6]};
		if (kind < 15) begin
			tok.is_load = 1'b1;
		end else if (kind < 25) begin
			tok.is_store = 1'b1;
		end else if (kind < 35) begin
			tok.is_branch = 1'b1;
			tok.br_taken  = r[9];
		end else if (kind < 41) begin
			tok.is_jump = 1'b1;
		end else if (kind < 45) begin
			tok.is_syscall = 1'b1;
		end
		return tok;
	endfunction

	function automatic string test_label(input int test);
		case (test)
			t_reset:    return "reset state";
			t_retire:   return "retire order";
			t_mem:      return "memory wait";
			t_load_use: return "load-use stall";
			default:    return "redirect and trap";
		endcase
	endfunction

	function automatic logic drained();
		return expect_q.size() == 0 && trap_q.size() == 0 && !in_shadow && wait_len == 0;
	endfunction

	// one look at the DUT per cycle, taken at the falling edge
	task automatic observe_cycle(input int cycle);
		pipe_pkg::instr_t tok;
		pipe_pkg::instr_t exp_tok;
		logic opens;
		logic is_wait;
		opens   = 1'b0;
		is_wait = (hazard == pipe_pkg::HZ_MEM_WAIT);
		tok     = fetch_instr;

		if (cycle < 4) begin
			compare_value(t_reset, retire.valid, 1'b0, "retire valid before first token");
		end
		if (cycle == 0) begin
			compare_value(t_reset, redirect, 1'b0, "redirect right after reset");
			compare_value(t_reset, trap_taken, 1'b0, "trap_taken right after reset");
		end

		// MEM/WB only loads after a cycle without memory wait
		if (retire.valid && !prev_wait) begin
			compare_value(t_retire, expect_q.size() != 0, 1'b1, "retire with nothing pending");
			if (expect_q.size() != 0) begin
				exp_tok = expect_q.pop_front();
				compare_value(t_retire, retire, exp_tok, "retired token");
				if (exp_tok.is_load || exp_tok.is_store) begin
					mem_retired++;
				end
			end
		end

		if (is_wait) begin
			if (wait_len == 0) begin
				wait_runs++;
				wait_retire = retire;
			end else begin
				compare_value(t_mem, retire, wait_retire, "retire changed in memory wait");
			end
			wait_len++;
			compare_value(t_mem, fetch_take, 1'b0, "fetch_take in memory wait");
		end else if (wait_len != 0) begin
			compare_value(t_mem, wait_len, mem_latency, "memory wait length");
			wait_len = 0;
		end
		prev_wait = is_wait;

		if (hazard == pipe_pkg::HZ_LOAD_USE) begin
			load_use_seen++;
		end

		if (redirect) begin
			compare_value(t_redirect, in_shadow, 1'b1, "redirect with no jump, branch or syscall");
		end
		if (trap_taken) begin
			compare_value(t_redirect, trap_q.size() != 0, 1'b1, "trap with no syscall pending");
			if (trap_q.size() != 0) begin
				compare_value(t_redirect, trap_tag, trap_q.pop_front(), "trap tag");
			end
		end

		if (fetch_take && tok.valid) begin
			if (in_shadow) begin
				prev_live = 1'b0;	// squashed on the way, never retires
			end else begin
				expect_q.push_back(tok);
				if (prev_live && prev_tok.is_load && prev_tok.rd != '0 && !tok.is_syscall &&
					(prev_tok.rd == tok.rs || prev_tok.rd == tok.rt)) begin
					load_use_exp++;
				end
				if (tok.is_syscall) begin
					trap_q.push_back(tok.tag);
				end
				opens     = tok.is_jump || tok.is_syscall || (tok.is_branch && tok.br_taken);
				prev_live = 1'b1;
				prev_tok  = tok;
			end
		end else if (fetch_take) begin
			prev_live = 1'b0;
		end
		if (redirect) begin
			in_shadow = 1'b0;	// token taken in the redirect cycle is still squashed
		end
		if (opens) begin
			in_shadow = 1'b1;
		end
		took = fetch_take;
	endtask

	task automatic step_cycle(input int cycle);
		@(negedge clk);
		observe_cycle(cycle);
		@(posedge clk);
		#2;
		if (took) begin
			if (feeding) begin
				fetch_instr = random_token(next_tag);
				next_tag    = next_tag + 1'b1;
			end else begin
				fetch_instr = '0;
			end
		end
	endtask

	initial begin
		int drain;
		int total_checks;
		int total_errs;
		void'($urandom(22379));
		clk           = 1'b0;
		arst_n        = 1'b0;
		fetch_instr   = '0;
		prev_tok      = '0;
		wait_retire   = '0;
		prev_live     = 1'b0;
		in_shadow     = 1'b0;
		took          = 1'b0;
		feeding       = 1'b1;
		prev_wait     = 1'b0;
		next_tag      = '0;
		wait_len      = 0;
		wait_runs     = 0;
		mem_retired   = 0;
		load_use_exp  = 0;
		load_use_seen = 0;
		total_checks  = 0;
		total_errs    = 0;
		for (int t = 0; t < n_tests; t++) begin
			checks[t] = 0;
			errs[t]   = 0;
		end
		fetch_instr = random_token(next_tag);
		next_tag    = next_tag + 1'b1;

		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			compare_value(t_reset, retire.valid, 1'b0, "retire valid in reset");
			compare_value(t_reset, redirect, 1'b0, "redirect in reset");
			compare_value(t_reset, trap_taken, 1'b0, "trap_taken in reset");
			compare_value(t_reset, hazard, pipe_pkg::HZ_NONE, "hazard in reset");
		end
		@(posedge clk);
		#2;
		arst_n = 1'b1;

		for (int c = 0; c < 4; c++) begin
			step_cycle(c);
		end
		$display("test %0d %s: %0d checks, %0d errors", t_reset, test_label(t_reset),
			checks[t_reset], errs[t_reset]);
		for (int c = 4; c < run_cycles; c++) begin
			step_cycle(c);
		end

		// stop feeding and let the pipeline empty
		feeding = 1'b0;
		drain   = 0;
		while (!drained() && drain < drain_limit) begin
			step_cycle(run_cycles + drain);
			drain++;
		end
		if (!drained()) begin
			$display("timeout: %0d tokens never retired within %0d drain cycles",
				expect_q.size(), drain_limit);
			errs[t_retire]++;
		end

		compare_value(t_mem, wait_runs, mem_retired, "memory waits against memory tokens");
		compare_value(t_load_use, load_use_seen, load_use_exp, "load-use stall cycles");
		for (int t = 1; t < n_tests; t++) begin
			$display("test %0d %s: %0d checks, %0d errors", t, test_label(t), checks[t], errs[t]);
		end
		for (int t = 0; t < n_tests; t++) begin
			total_checks += checks[t];
			total_errs   += errs[t];
		end
		total_errs += u_dut.u_props.fail_count;	// failed concurrent assertions
		$display("total: %0d checks, %0d errors, %0d load-use stalls, %0d memory waits",
			total_checks, total_errs, load_use_seen, wait_runs);
		if (total_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tb.f
verilog/pipe_pkg.sv
verilog/hazard_detect.sv
verilog/trap_seq.sv
verilog/mem_wait_timer.sv
verilog/stage_regs.sv
verilog/pipe_ctrl_top.sv
sim/pipe_ctrl_properties.sv
sim/pipe_ctrl_tb.sv
